// ==== ramio.f ====
src/ramio_pkg.sv
src/lane_align.sv
src/word_ram.sv
src/baud_timer.sv
src/uart_tx.sv
src/uart_rx.sv
src/ramio.sv
verification/ramio_tb.sv

// ==== verification/ramio_tb.sv ====
/*
  Table-driven testbench for the memory-mapped I/O bridge.
  Rows are built up front against a reference word model, then applied in
  order through the client handshake, a serial driver and a serial monitor.
*/
`timescale 1ns/1ps
`default_nettype none

module ramio_tb
  import ramio_pkg::*;
();

  localparam int ACCESS_TIMEOUT = 20;
  localparam int FRAME_TIMEOUT  = 4 * CLKS_PER_BIT;

  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_SER_IN, OP_SER_OUT, OP_LED} op_t;

  // one table row, exp_data is only used by reads and checks
  typedef struct packed {
    op_t         op;
    addr_t       addr;
    read_type_t  rtype;
    write_type_t wtype;
    word_t       wdata;
    word_t       exp_data;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        enable_i;
  addr_t       address_i;
  read_type_t  read_type_i;
  write_type_t write_type_i;
  word_t       data_i;
  word_t       data_o;
  logic        data_out_ready_o;
  logic        busy_o;
  logic [3:0]  led_o;
  logic        uart_tx_o;
  logic        uart_rx_i;

  integer seed;
  row_t   rows[$];
  // reference contents of the RAM, indexed by word
  word_t  model_mem [RAM_DEPTH];

  ramio dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable_i),
    .address_i       (address_i),
    .read_type_i     (read_type_i),
    .write_type_i    (write_type_i),
    .data_i          (data_i),
    .data_o          (data_o),
    .data_out_ready_o(data_out_ready_o),
    .busy_o          (busy_o),
    .led_o           (led_o),
    .uart_tx_o       (uart_tx_o),
    .uart_rx_i       (uart_rx_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // size in bytes from the low two bits of an access type
  function automatic int size_bytes(input logic [1:0] code);
    case (code)
      2'b01: return 1;
      2'b10: return 2;
      2'b11: return 4;
      default: return 0;
    endcase
  endfunction

  function automatic void model_write(input addr_t addr, input write_type_t wt,
                                      input word_t data);
    int nbytes;
    int off;
    int idx;
    nbytes = size_bytes(wt);
    off    = addr[1:0];
    idx    = (addr >> 2) % RAM_DEPTH;
    // misaligned half words leave memory alone
    if (nbytes == 0 || off % nbytes != 0) return;
    for (int i = 0; i < nbytes; i++) begin
      model_mem[idx][8*(off+i) +: 8] = data[8*i +: 8];
    end
  endfunction

  function automatic word_t model_read(input addr_t addr, input read_type_t rt);
    word_t w;
    word_t v;
    word_t mask;
    int    nbytes;
    int    off;
    w      = model_mem[(addr >> 2) % RAM_DEPTH];
    nbytes = size_bytes(rt[1:0]);
    off    = addr[1:0];
    if (nbytes == 0 || off % nbytes != 0) return '0;
    if (nbytes == 4) return w;
    mask = (32'h1 << (8 * nbytes)) - 1;
    v    = (w >> (8 * off)) & mask;
    // bit 2 of the read type asks for sign extension
    if (rt[2] && v[8*nbytes-1]) v = v | ~mask;
    return v;
  endfunction

  task automatic push_row(input op_t op, input addr_t addr, input read_type_t rt,
                          input write_type_t wt, input word_t wd, input word_t exp);
    row_t r;
    r.op       = op;
    r.addr     = addr;
    r.rtype    = rt;
    r.wtype    = wt;
    r.wdata    = wd;
    r.exp_data = exp;
    rows.push_back(r);
  endtask

  task automatic ram_write_row(input addr_t addr, input write_type_t wt, input word_t wd);
    model_write(addr, wt, wd);
    push_row(OP_WRITE, addr, 3'b000, wt, wd, '0);
  endtask

  task automatic ram_read_row(input addr_t addr, input read_type_t rt);
    push_row(OP_READ, addr, rt, 2'b00, '0, model_read(addr, rt));
  endtask

  task automatic build_table();
    addr_t base;
    byte_t tx_byte;
    byte_t rx_byte;
    word_t led_val;
    // whole words, 0x500 aliases onto 0x100
    ram_write_row(32'h0000_0000, SZ_WORD, $random(seed));
    ram_write_row(32'h0000_0004, SZ_WORD, $random(seed));
    ram_write_row(32'h0000_0100, SZ_WORD, $random(seed));
    ram_write_row(32'h0000_03FC, SZ_WORD, $random(seed));
    ram_read_row(32'h0000_0000, 3'b011);
    ram_read_row(32'h0000_0004, 3'b011);
    ram_read_row(32'h0000_03FC, 3'b011);
    ram_read_row(32'h0000_0500, 3'b011);
    // partial writes merging into one word, top bits forced for sign tests
    base = 32'h0000_0040;
    ram_write_row(base, SZ_WORD, $random(seed));
    ram_write_row(base + 1, SZ_BYTE, $random(seed) | 32'h80);
    ram_write_row(base + 2, SZ_HALF, $random(seed) | 32'h8000);
    ram_read_row(base, 3'b011);
    // odd half-word offsets must not touch memory
    ram_write_row(base + 1, SZ_HALF, $random(seed));
    ram_write_row(base + 3, SZ_HALF, $random(seed));
    ram_read_row(base, 3'b011);
    for (int off = 0; off < 4; off++) begin
      ram_read_row(base + off, 3'b001);
      ram_read_row(base + off, 3'b101);
    end
    ram_read_row(base, 3'b010);
    ram_read_row(base, 3'b110);
    ram_read_row(base + 2, 3'b010);
    ram_read_row(base + 2, 3'b110);
    ram_read_row(base + 1, 3'b110);
    ram_read_row(base + 3, 3'b010);
    // outer lanes of a second word
    base = 32'h0000_0080;
    ram_write_row(base, SZ_WORD, $random(seed));
    ram_write_row(base + 3, SZ_BYTE, $random(seed) | 32'h80);
    ram_write_row(base, SZ_BYTE, $random(seed));
    ram_read_row(base, 3'b011);
    ram_read_row(base + 3, 3'b101);
    // registers straight out of reset
    push_row(OP_LED, '0, 3'b000, 2'b00, '0, 32'h0000_000F);
    push_row(OP_READ, ADDR_UART_IN, 3'b011, 2'b00, '0, 32'hFFFF_FFFF);
    push_row(OP_READ, ADDR_UART_OUT, 3'b011, 2'b00, '0, 32'hFFFF_FFFF);
    // transmit one frame, register idles back to all ones
    tx_byte = $random(seed);
    push_row(OP_WRITE, ADDR_UART_OUT, 3'b000, SZ_WORD, {24'h0, tx_byte}, '0);
    push_row(OP_SER_OUT, '0, 3'b000, 2'b00, '0, {24'h0, tx_byte});
    push_row(OP_READ, ADDR_UART_OUT, 3'b011, 2'b00, '0, 32'hFFFF_FFFF);
    // receive one byte, the first read clears it
    rx_byte = $random(seed);
    push_row(OP_SER_IN, '0, 3'b000, 2'b00, {24'h0, rx_byte}, '0);
    push_row(OP_READ, ADDR_UART_IN, 3'b011, 2'b00, '0, {24'h0, rx_byte});
    push_row(OP_READ, ADDR_UART_IN, 3'b011, 2'b00, '0, 32'hFFFF_FFFF);
    led_val = $random(seed);
    push_row(OP_WRITE, ADDR_LED, 3'b000, SZ_WORD, led_val, '0);
    push_row(OP_LED, '0, 3'b000, 2'b00, '0, {28'h0, led_val[3:0]});
    push_row(OP_READ, ADDR_LED, 3'b011, 2'b00, '0, {28'h0, led_val[3:0]});
  endtask

  // one client request, held until data_out_ready_o
  task automatic run_access(input addr_t addr, input read_type_t rt, input write_type_t wt,
                            input word_t wd, output word_t rd);
    int   waited;
    logic busy_seen;
    logic is_io;
    waited    = 0;
    busy_seen = 1'b0;
    is_io     = (addr == ADDR_LED) || (addr == ADDR_UART_OUT) || (addr == ADDR_UART_IN);
    @(posedge clk);
    enable_i     <= 1'b1;
    address_i    <= addr;
    read_type_i  <= rt;
    write_type_i <= wt;
    data_i       <= wd;
    @(negedge clk);
    while (data_out_ready_o !== 1'b1) begin
      if (busy_o === 1'b1) busy_seen = 1'b1;
      if (waited == ACCESS_TIMEOUT) abort_run("timeout waiting for data_out_ready_o");
      waited++;
      @(negedge clk);
    end
    rd = data_o;
    check_value("busy_o", busy_o, 32'h0);
    if (!is_io && rt != 3'b000) begin
      // registered RAM read, busy first then ready
      if (!busy_seen) abort_run("RAM read finished without busy_o");
      check_value("read cycles", waited, 32'd2);
    end else begin
      if (busy_seen) abort_run("busy_o raised on a single cycle access");
      check_value("ready cycles", waited, 32'd0);
    end
    @(posedge clk);
    enable_i     <= 1'b0;
    read_type_i  <= 3'b000;
    write_type_i <= 2'b00;
  endtask

  // 8N1 frame into the receiver
  task automatic send_serial(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      uart_rx_i <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  // samples each bit of one frame near its middle
  task automatic capture_serial(input byte_t exp_byte);
    int    waited;
    byte_t got;
    waited = 0;
    @(negedge clk);
    while (uart_tx_o !== 1'b0) begin
      if (waited == FRAME_TIMEOUT) abort_run("no start bit seen on uart_tx_o");
      waited++;
      @(negedge clk);
    end
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    if (uart_tx_o !== 1'b0) abort_run("start bit on uart_tx_o ended early");
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      got[i] = uart_tx_o;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_value("uart_tx_o stop bit", uart_tx_o, 32'h1);
    check_value("uart_tx_o byte", got, exp_byte);
    // let the stop bit finish
    repeat (CLKS_PER_BIT / 2 + 2) @(negedge clk);
  endtask

  task automatic apply_row(input row_t r);
    word_t got;
    case (r.op)
      OP_WRITE: run_access(r.addr, 3'b000, r.wtype, r.wdata, got);
      OP_READ: begin
        run_access(r.addr, r.rtype, 2'b00, '0, got);
        check_value("data_o", got, r.exp_data);
      end
      OP_SER_IN: send_serial(r.wdata[7:0]);
      OP_SER_OUT: capture_serial(r.exp_data[7:0]);
      OP_LED: begin
        @(negedge clk);
        check_value("led_o", {28'h0, led_o}, r.exp_data);
      end
      default: abort_run("unknown operation in stimulus table");
    endcase
  endtask

  initial begin
    seed         = 32'hea09;
    rst_n        = 1'b0;
    enable_i     = 1'b0;
    address_i    = '0;
    read_type_i  = 3'b000;
    write_type_i = 2'b00;
    data_i       = '0;
    uart_rx_i    = 1'b1;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("uart_tx_o", uart_tx_o, 32'h1);
    check_value("busy_o", busy_o, 32'h0);
    check_value("data_out_ready_o", data_out_ready_o, 32'h0);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/ramio.sv ====
/*
  Memory-mapped bridge for a soft processor. Client accesses go to the
  word RAM or to the LED and UART registers. Handshake is enable, busy
  and data-ready, a RAM read takes two clocks, everything else completes
  in the request cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module ramio
  import ramio_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable_i,
  input  addr_t       address_i,
  input  read_type_t  read_type_i,
  input  write_type_t write_type_i,
  input  word_t       data_i,
  output word_t       data_o,
  output logic        data_out_ready_o,
  output logic        busy_o,
  output logic [3:0]  led_o,
  output logic        uart_tx_o,
  input  logic        uart_rx_i
);

  logic      io_led, io_out, io_in, io_hit;
  logic      wr_req, rd_req;
  logic      ram_wr, ram_rd_start, ram_en;
  logic      rd_pend_q, rd_busy_q, rd_done_q;
  word_t     ram_wdata, ram_rdata, ram_rd_value;
  be_t       ram_be;
  byte_t     tx_byte_q, rx_data;
  logic      tx_valid_q, tx_ready, rx_valid;
  word_t     tx_rd_value, rx_reg_q;
  logic [3:0] led_q;

  // I/O decode wins over RAM
  assign io_led = (address_i == ADDR_LED);
  assign io_out = (address_i == ADDR_UART_OUT);
  assign io_in  = (address_i == ADDR_UART_IN);
  assign io_hit = io_led || io_out || io_in;

  assign wr_req = enable_i && (write_type_i != '0);
  assign rd_req = enable_i && (read_type_i != '0);

  // one read per enable, pending flag blocks a restart
  assign ram_wr       = wr_req && !io_hit;
  assign ram_rd_start = rd_req && !wr_req && !io_hit && !rd_pend_q;
  assign ram_en       = ram_wr || ram_rd_start;

  assign busy_o           = rd_busy_q;
  assign data_out_ready_o = (enable_i && io_hit) || ram_wr || rd_done_q;
  assign led_o            = led_q;

  // all ones once the transmitter is idle with nothing queued
  assign tx_rd_value = (tx_valid_q || !tx_ready) ? {24'h0, tx_byte_q} : '1;

  always_comb begin
    if (io_led) data_o = {28'h0, led_q};
    else if (io_out) data_o = tx_rd_value;
    else if (io_in) data_o = rx_reg_q;
    else data_o = ram_rd_value;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend_q  <= 1'b0;
      rd_busy_q  <= 1'b0;
      rd_done_q  <= 1'b0;
      tx_valid_q <= 1'b0;
      rx_reg_q   <= '1;
      led_q      <= 4'hF;
    end else begin
      // RAM data is registered, ready follows busy by one clock
      rd_busy_q <= ram_rd_start;
      rd_done_q <= rd_busy_q;
      if (!enable_i) rd_pend_q <= 1'b0;
      else if (ram_rd_start) rd_pend_q <= 1'b1;
      // a new write replaces a byte not yet accepted
      if (wr_req && io_out) tx_valid_q <= 1'b1;
      else if (tx_ready) tx_valid_q <= 1'b0;
      // incoming byte beats a clearing read
      if (rx_valid) rx_reg_q <= {24'h0, rx_data};
      else if (rd_req && io_in) rx_reg_q <= '1;
      // LEDs are active low
      if (wr_req && io_led) led_q <= data_i[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req && io_out) tx_byte_q <= data_i[7:0];
  end

  lane_align u_lane_align (
    .addr_lo_i   (address_i[1:0]),
    .read_type_i (read_type_i),
    .write_type_i(write_type_i),
    .wdata_i     (data_i),
    .ram_rdata_i (ram_rdata),
    .ram_wdata_o (ram_wdata),
    .ram_be_o    (ram_be),
    .rdata_o     (ram_rd_value)
  );

  // word address, upper bits alias
  word_ram u_word_ram (
    .clk    (clk),
    .en_i   (ram_en),
    .be_i   (ram_be),
    .addr_i (address_i[RAM_ADDR_W+1:2]),
    .wdata_i(ram_wdata),
    .rdata_o(ram_rdata)
  );

  uart_tx u_uart_tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .data_i (tx_byte_q),
    .valid_i(tx_valid_q),
    .ready_o(tx_ready),
    .tx_o   (uart_tx_o)
  );

  uart_rx u_uart_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx_i   (uart_rx_i),
    .data_o (rx_data),
    .valid_o(rx_valid)
  );

  busy_ready_excl_a : assert property (@(posedge clk) disable iff (!rst_n)
    !(busy_o && data_out_ready_o));

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
/*
  8N1 UART receiver. The line is synchronized, a falling edge starts a
  half-bit wait and each bit is sampled at mid-bit. valid_o pulses for one
  cycle with each byte whose stop bit reads 1, there is no back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import ramio_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx_i,
  output byte_t data_o,
  output logic  valid_o
);

  rx_state_t  state_q;
  logic       rx_s1_q;
  logic       rx_s2_q;
  logic       rx_d_q;
  logic [2:0] bit_cnt_q;
  byte_t      shift_q;
  logic       valid_q;
  logic       tick;
  logic       start_edge;

  // falling edge of the synchronized line while idle
  assign start_edge = (state_q == RX_IDLE) && rx_d_q && !rx_s2_q;
  assign data_o     = shift_q;
  assign valid_o    = valid_q;

  baud_timer u_baud_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart_i(start_edge),
    .half_i   (1'b1),
    .tick_o   (tick)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // idle line is high
      rx_s1_q   <= 1'b1;
      rx_s2_q   <= 1'b1;
      rx_d_q    <= 1'b1;
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      rx_s1_q <= rx_i;
      rx_s2_q <= rx_s1_q;
      rx_d_q  <= rx_s2_q;
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (start_edge) state_q <= RX_START;
        end
        RX_START: begin
          if (tick) begin
            // still low at mid-bit, otherwise a glitch
            state_q   <= rx_s2_q ? RX_IDLE : RX_DATA;
            bit_cnt_q <= '0;
          end
        end
        RX_DATA: begin
          if (tick) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (tick) begin
            // framing error drops the byte
            valid_q <= rx_s2_q;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && tick) shift_q <= {rx_s2_q, shift_q[7:1]};
  end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
/*
  8N1 UART transmitter with a valid/ready input.
  A byte is accepted only in IDLE, then start, eight data bits LSB first
  and a stop bit are shifted out on the baud ticks.
*/
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import ramio_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output logic  tx_o
);

  tx_state_t  state_q;
  byte_t      shift_q;
  logic [2:0] bit_cnt_q;
  logic       tx_q;
  logic       tick;
  logic       accept;

  assign ready_o = (state_q == TX_IDLE);
  assign accept  = valid_i && ready_o;
  assign tx_o    = tx_q;

  // timer restarts with the start bit
  baud_timer u_baud_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart_i(accept),
    .half_i   (1'b0),
    .tick_o   (tick)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= TX_IDLE;
      tx_q      <= 1'b1;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (accept) begin
            state_q <= TX_START;
            tx_q    <= 1'b0;
          end
        end
        TX_START: begin
          if (tick) begin
            state_q   <= TX_DATA;
            tx_q      <= shift_q[0];
            bit_cnt_q <= '0;
          end
        end
        TX_DATA: begin
          if (tick) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= TX_STOP;
              tx_q    <= 1'b1;
            end else begin
              // next bit, shift_q moves in step below
              tx_q <= shift_q[1];
            end
          end
        end
        TX_STOP: begin
          if (tick) state_q <= TX_IDLE;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // byte latched at acceptance
  always_ff @(posedge clk) begin
    if (accept) shift_q <= data_i;
    else if (state_q == TX_DATA && tick) shift_q <= shift_q >> 1;
  end

  // a frame keeps ready low for exactly ten bit periods
  frame_len_a : assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !ready_o [*10*CLKS_PER_BIT] ##1 ready_o);

endmodule

`default_nettype wire

// ==== src/baud_timer.sv ====
/*
  Bit period timer for the UART state machines.
  Restart loads a full or half period, tick_o marks the end of each period.
*/
`timescale 1ns/1ps
`default_nettype none

module baud_timer
  import ramio_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic restart_i,
  input  logic half_i,
  output logic tick_o
);

  baud_cnt_t cnt_q;

  // one-cycle pulse when the count runs out
  assign tick_o = (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= BAUD_FULL;
    end else if (restart_i) begin
      // half period lands the next tick at mid-bit
      cnt_q <= half_i ? BAUD_HALF : BAUD_FULL;
    end else if (tick_o) begin
      cnt_q <= BAUD_FULL;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/word_ram.sv ====
/*
  Single-port word RAM with per-byte write enables.
  Read data is registered and appears one clock after en_i.
*/
`timescale 1ns/1ps
`default_nettype none

module word_ram
  import ramio_pkg::*;
(
  input  logic      clk,
  input  logic      en_i,
  input  be_t       be_i,
  input  ram_addr_t addr_i,
  input  word_t     wdata_i,
  output word_t     rdata_o
);

  // contents undefined until written
  word_t mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (en_i) begin
      for (int i = 0; i < 4; i++) begin
        // only the enabled lanes change
        if (be_i[i]) mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
      end
      // old data on a read during write
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== src/lane_align.sv ====
/*
  Byte lane steering between the client and the 32-bit word RAM.
  Writes are replicated into their lane with byte enables, reads are
  extracted from their lane and sign or zero extended. Purely combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module lane_align
  import ramio_pkg::*;
(
  input  logic [1:0]  addr_lo_i,
  input  read_type_t  read_type_i,
  input  write_type_t write_type_i,
  input  word_t       wdata_i,
  input  word_t       ram_rdata_i,
  output word_t       ram_wdata_o,
  output be_t         ram_be_o,
  output word_t       rdata_o
);

  byte_t       rd_byte;
  logic [15:0] rd_half;
  logic        sign_ext;

  // write side
  always_comb begin
    // data is replicated, enables pick the lane
    ram_wdata_o = '0;
    ram_be_o    = '0;
    case (write_type_i)
      SZ_BYTE: begin
        ram_wdata_o = {4{wdata_i[7:0]}};
        ram_be_o    = be_t'(4'b0001 << addr_lo_i);
      end
      SZ_HALF: begin
        ram_wdata_o = {2{wdata_i[15:0]}};
        // odd half-word address writes nothing
        if (!addr_lo_i[0]) ram_be_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
      end
      SZ_WORD: begin
        ram_wdata_o = wdata_i;
        ram_be_o    = 4'b1111;
      end
      default: ;
    endcase
  end

  // read side
  always_comb begin
    rd_byte  = ram_rdata_i[{addr_lo_i, 3'b000} +: 8];
    rd_half  = addr_lo_i[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];
    sign_ext = read_type_i[2];
    case (read_type_i[1:0])
      SZ_BYTE: rdata_o = {{24{sign_ext & rd_byte[7]}}, rd_byte};
      // misaligned half word reads as zero
      SZ_HALF: rdata_o = addr_lo_i[0] ? '0 : {{16{sign_ext & rd_half[15]}}, rd_half};
      SZ_WORD: rdata_o = ram_rdata_i;
      default: rdata_o = '0;
    endcase
  end

  // the client keeps word accesses aligned
  always_comb begin
    word_aligned_a : assert final (!((read_type_i[1:0] === SZ_WORD ||
                                      write_type_i === SZ_WORD) &&
                                     addr_lo_i !== 2'b00))
      else $error("word access at unaligned offset %0d", addr_lo_i);
  end

endmodule

`default_nettype wire

// ==== src/ramio_pkg.sv ====
/*
  Shared types and constants for the memory-mapped I/O bridge.
  Modules pull these in with a wildcard import in their header.
*/
`default_nettype none

package ramio_pkg;

  // client side widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  be_t;

  // 000 no read, [1:0] size, [2] sign extend
  typedef logic [2:0] read_type_t;
  // 00 no write, else size
  typedef logic [1:0] write_type_t;

  // size codes shared by read and write types
  localparam logic [1:0] SZ_BYTE = 2'b01;
  localparam logic [1:0] SZ_HALF = 2'b10;
  localparam logic [1:0] SZ_WORD = 2'b11;

  // on-chip word RAM, higher addresses alias
  localparam int RAM_ADDR_W = 8;
  localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

  // I/O map at the top of the address space
  localparam addr_t ADDR_LED      = 32'hFFFF_FFFC;
  localparam addr_t ADDR_UART_OUT = 32'hFFFF_FFF8;
  localparam addr_t ADDR_UART_IN  = 32'hFFFF_FFF4;

  // UART bit period in clocks
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_W       = $clog2(CLKS_PER_BIT);
  typedef logic [BAUD_W-1:0] baud_cnt_t;
  localparam baud_cnt_t BAUD_FULL = baud_cnt_t'(CLKS_PER_BIT - 1);
  // mid-bit offset used after a start edge
  localparam baud_cnt_t BAUD_HALF = baud_cnt_t'((CLKS_PER_BIT - 1) / 2);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire
